// File: yaw_pkg.sv
package yaw_pkg;

    // Heading, heading error, normalised stick and scaled heading, 1/16 degree per count
    typedef logic signed [15:0] angle_t;

    // Raw receiver stick value
    typedef logic [7:0] stick_t;

    // One step per clock, in this fixed order
    typedef enum logic [3:0] {
        STEP_INIT,
        STEP_WAIT,
        STEP_LATCH,
        STEP_NEUTRAL,
        STEP_NORMALIZE,
        STEP_WINDOW,
        STEP_TRACK_SUM,
        STEP_TRACK_WRAP,
        STEP_TRACK_LIMIT,
        STEP_TARGET,
        STEP_ERROR_DIFF,
        STEP_ERROR_WRAP,
        STEP_ERROR_HOLD,
        STEP_ERROR_CLAMP,
        STEP_COMPLETE
    } yaw_step_e;

    // 16 counts per degree
    localparam angle_t ANGLE_360 = 16'sd5760;
    localparam angle_t ANGLE_270 = 16'sd4320;
    localparam angle_t ANGLE_90  = 16'sd1440;

    // Tracked heading runs at 4x resolution
    localparam int     SCALE_BITS       = 2;
    localparam angle_t ANGLE_360_SCALED = ANGLE_360 <<< SCALE_BITS;

    // Throttle below this value is treated as idle
    localparam stick_t THROTTLE_IDLE_LIMIT = 8'd10;

    // Normalised stick strictly inside +/- this value is neutral
    localparam angle_t STICK_DEADBAND = 16'sd4;

    // Stick multiplier in acro mode
    localparam angle_t ACRO_GAIN = 16'sd2;

endpackage

// File: yaw_sample_if.sv
`timescale 1ns/1ps

interface yaw_sample_if
    import yaw_pkg::*;
();

    logic   throttle_idle;
    angle_t yaw_raw;
    angle_t stick_norm;
    logic   out_of_window;
    // Glitch-filtered IMU heading
    angle_t imu_angle;

    modport source (
        output throttle_idle,
        output yaw_raw,
        output stick_norm,
        output out_of_window,
        output imu_angle
    );

    modport sink (
        input throttle_idle,
        input yaw_raw,
        input stick_norm,
        input out_of_window,
        input imu_angle
    );

endinterface

// File: yaw_step_sequencer.sv
`timescale 1ns/1ps

module yaw_step_sequencer
    import yaw_pkg::*;
(
    input  logic      us_clk,
    input  logic      resetn,
    input  logic      start,
    input  logic      imu_ready,
    output yaw_step_e step,
    output logic      active,
    output logic      complete
);

    yaw_step_e next_step;
    logic      start_flag;

    // Start request flag, kept while start is held so a request during an iteration survives
    always_ff @(posedge us_clk or negedge resetn) begin
        if (!resetn) begin
            start_flag <= 1'b0;
        end else if (start) begin
            start_flag <= 1'b1;
        end else if (step != STEP_WAIT) begin
            start_flag <= 1'b0;
        end
    end

    always_comb begin
        case (step)
            STEP_INIT: begin
                // Hold off until the IMU reports valid data
                next_step = imu_ready ? STEP_WAIT : STEP_INIT;
            end
            STEP_WAIT: begin
                next_step = start_flag ? STEP_LATCH : STEP_WAIT;
            end
            STEP_LATCH:       next_step = STEP_NEUTRAL;
            STEP_NEUTRAL:     next_step = STEP_NORMALIZE;
            STEP_NORMALIZE:   next_step = STEP_WINDOW;
            STEP_WINDOW:      next_step = STEP_TRACK_SUM;
            STEP_TRACK_SUM:   next_step = STEP_TRACK_WRAP;
            STEP_TRACK_WRAP:  next_step = STEP_TRACK_LIMIT;
            STEP_TRACK_LIMIT: next_step = STEP_TARGET;
            STEP_TARGET:      next_step = STEP_ERROR_DIFF;
            STEP_ERROR_DIFF:  next_step = STEP_ERROR_WRAP;
            STEP_ERROR_WRAP:  next_step = STEP_ERROR_HOLD;
            STEP_ERROR_HOLD:  next_step = STEP_ERROR_CLAMP;
            STEP_ERROR_CLAMP: next_step = STEP_COMPLETE;
            STEP_COMPLETE:    next_step = STEP_WAIT;
            default:          next_step = STEP_INIT;
        endcase
    end

    always_ff @(posedge us_clk or negedge resetn) begin
        if (!resetn) begin
            step <= STEP_INIT;
        end else begin
            step <= next_step;
        end
    end

    // Flags follow the step register exactly, taken from the next step
    always_ff @(posedge us_clk or negedge resetn) begin
        if (!resetn) begin
            active   <= 1'b0;
            complete <= 1'b0;
        end else begin
            active   <= (next_step >= STEP_LATCH) && (next_step <= STEP_ERROR_CLAMP);
            complete <= (next_step == STEP_COMPLETE);
        end
    end

endmodule

// File: yaw_stick_conditioner.sv
`timescale 1ns/1ps

module yaw_stick_conditioner
    import yaw_pkg::*;
(
    input  logic        us_clk,
    input  logic        resetn,
    input  yaw_step_e   step,
    input  stick_t      throttle,
    input  stick_t      yaw,
    input  angle_t      imu_angle,
    input  logic        acro_mode,
    yaw_sample_if.source sample
);

    // Stick value seen while the throttle was last idle
    angle_t neutral;
    angle_t stick_delta;
    logic   imu_glitch;

    assign stick_delta = sample.yaw_raw - neutral;
    assign imu_glitch  = (imu_angle < 0) || (imu_angle > ANGLE_360);

    always_ff @(posedge us_clk or negedge resetn) begin
        if (!resetn) begin
            sample.throttle_idle <= 1'b0;
            sample.yaw_raw       <= '0;
            sample.imu_angle     <= '0;
        end else if (step == STEP_LATCH) begin
            sample.throttle_idle <= (throttle < THROTTLE_IDLE_LIMIT);
            sample.yaw_raw       <= angle_t'({8'd0, yaw});
            // Out-of-range IMU data keeps the last accepted heading
            if (!imu_glitch) begin
                sample.imu_angle <= imu_angle;
            end
        end
    end

    always_ff @(posedge us_clk or negedge resetn) begin
        if (!resetn) begin
            neutral <= '0;
        end else if ((step == STEP_NEUTRAL) && sample.throttle_idle) begin
            neutral <= sample.yaw_raw;
        end
    end

    always_ff @(posedge us_clk or negedge resetn) begin
        if (!resetn) begin
            sample.stick_norm <= '0;
        end else if (step == STEP_NORMALIZE) begin
            if (acro_mode) begin
                sample.stick_norm <= stick_delta * ACRO_GAIN;
            end else begin
                // Easy mode halves the stick rate
                sample.stick_norm <= stick_delta >>> 1;
            end
        end
    end

    // Stick counts as active only with throttle on and outside the deadband
    always_ff @(posedge us_clk or negedge resetn) begin
        if (!resetn) begin
            sample.out_of_window <= 1'b0;
        end else if (step == STEP_WINDOW) begin
            if (sample.throttle_idle) begin
                sample.out_of_window <= 1'b0;
            end else begin
                sample.out_of_window <= (sample.stick_norm >= STICK_DEADBAND) ||
                                        (sample.stick_norm <= -STICK_DEADBAND);
            end
        end
    end

endmodule

// File: yaw_target_tracker.sv
`timescale 1ns/1ps

module yaw_target_tracker
    import yaw_pkg::*;
(
    input  logic        us_clk,
    input  logic        resetn,
    input  yaw_step_e   step,
    yaw_sample_if.sink  sample,
    input  angle_t      error_raw,
    input  logic        yaac_enable_n,
    output angle_t      target_angle
);

    // Scaled heading, its unwrapped sum and the value from the previous iteration
    angle_t track;
    angle_t track_sum;
    angle_t track_prev;
    logic   limit_hit;

    // Error already at a limit and the stick pushes further the same way
    assign limit_hit = ((error_raw >= ANGLE_90) && (sample.stick_norm > 0)) ||
                       ((error_raw <= -ANGLE_90) && (sample.stick_norm < 0));

    always_ff @(posedge us_clk) begin
        if (step == STEP_TRACK_SUM) begin
            track_sum <= track + sample.stick_norm;
        end
    end

    always_ff @(posedge us_clk or negedge resetn) begin
        if (!resetn) begin
            track <= '0;
        end else begin
            case (step)
                STEP_TRACK_WRAP: begin
                    if (sample.throttle_idle) begin
                        // Idle throttle follows the IMU heading
                        track <= sample.imu_angle <<< SCALE_BITS;
                    end else if (sample.out_of_window) begin
                        if (track_sum > ANGLE_360_SCALED) begin
                            track <= track_sum - ANGLE_360_SCALED;
                        end else if (track_sum < 0) begin
                            track <= track_sum + ANGLE_360_SCALED;
                        end else begin
                            track <= track_sum;
                        end
                    end
                end
                STEP_TRACK_LIMIT: begin
                    if (limit_hit) begin
                        track <= track_prev;
                    end
                end
                default: begin
                    track <= track;
                end
            endcase
        end
    end

    always_ff @(posedge us_clk or negedge resetn) begin
        if (!resetn) begin
            track_prev   <= '0;
            target_angle <= '0;
        end else if (step == STEP_TARGET) begin
            if (sample.throttle_idle) begin
                target_angle <= sample.imu_angle;
            end else begin
                target_angle <= track >>> SCALE_BITS;
            end
        end else if (step == STEP_ERROR_CLAMP) begin
            track_prev <= track;
            // Bypass passes the raw stick straight through
            if (yaac_enable_n) begin
                target_angle <= sample.yaw_raw;
            end
        end
    end

endmodule

// File: yaw_error_calc.sv
`timescale 1ns/1ps

module yaw_error_calc
    import yaw_pkg::*;
(
    input  logic        us_clk,
    input  logic        resetn,
    input  yaw_step_e   step,
    yaw_sample_if.sink  sample,
    input  angle_t      target_angle,
    input  logic        yaac_enable_n,
    output angle_t      error_raw,
    output angle_t      error_angle
);

    angle_t error_diff;
    angle_t error_prev;
    logic   target_high;
    logic   imu_high;

    // Headings on opposite sides of the 0/360 seam
    assign target_high = (target_angle > ANGLE_270) && (sample.imu_angle < ANGLE_90);
    assign imu_high    = (sample.imu_angle > ANGLE_270) && (target_angle < ANGLE_90);

    always_ff @(posedge us_clk) begin
        if (step == STEP_ERROR_DIFF) begin
            error_diff <= target_angle - sample.imu_angle;
        end
    end

    always_ff @(posedge us_clk or negedge resetn) begin
        if (!resetn) begin
            error_raw <= '0;
        end else if (step == STEP_ERROR_WRAP) begin
            if (sample.throttle_idle) begin
                error_raw <= '0;
            end else if (target_high) begin
                error_raw <= -(ANGLE_360 - target_angle + sample.imu_angle);
            end else if (imu_high) begin
                error_raw <= ANGLE_360 - sample.imu_angle + target_angle;
            end else begin
                error_raw <= error_diff;
            end
        end else if (step == STEP_ERROR_HOLD) begin
            // Never flip from one limit straight to the other
            if ((error_prev >= ANGLE_90) && (error_raw <= -ANGLE_90)) begin
                error_raw <= ANGLE_90;
            end else if ((error_prev <= -ANGLE_90) && (error_raw >= ANGLE_90)) begin
                error_raw <= -ANGLE_90;
            end
        end
    end

    always_ff @(posedge us_clk or negedge resetn) begin
        if (!resetn) begin
            error_prev  <= '0;
            error_angle <= '0;
        end else if (step == STEP_ERROR_CLAMP) begin
            error_prev <= error_raw;
            if (yaac_enable_n) begin
                error_angle <= '0;
            end else if (error_raw > ANGLE_90) begin
                error_angle <= ANGLE_90;
            end else if (error_raw < -ANGLE_90) begin
                error_angle <= -ANGLE_90;
            end else begin
                error_angle <= error_raw;
            end
        end
    end

endmodule

// File: yaw_angle_accumulator.sv
`timescale 1ns/1ps

module yaw_angle_accumulator
    import yaw_pkg::*;
(
    input  logic   us_clk,
    input  logic   resetn,
    input  stick_t throttle,
    input  stick_t yaw,
    input  angle_t imu_angle,
    input  logic   imu_ready,
    input  logic   start,
    input  logic   acro_mode,
    input  logic   yaac_enable_n,
    output angle_t target_angle,
    output angle_t error_angle,
    output logic   active,
    output logic   complete,
    output logic   stick_active
);

    yaw_step_e step;
    angle_t    error_raw;

    // Conditioned sample shared by both datapath stages
    yaw_sample_if sample_bus ();

    yaw_step_sequencer u_seq (
        .us_clk    (us_clk),
        .resetn    (resetn),
        .start     (start),
        .imu_ready (imu_ready),
        .step      (step),
        .active    (active),
        .complete  (complete)
    );

    yaw_stick_conditioner u_cond (
        .us_clk    (us_clk),
        .resetn    (resetn),
        .step      (step),
        .throttle  (throttle),
        .yaw       (yaw),
        .imu_angle (imu_angle),
        .acro_mode (acro_mode),
        .sample    (sample_bus.source)
    );

    yaw_target_tracker u_track (
        .us_clk        (us_clk),
        .resetn        (resetn),
        .step          (step),
        .sample        (sample_bus.sink),
        .error_raw     (error_raw),
        .yaac_enable_n (yaac_enable_n),
        .target_angle  (target_angle)
    );

    yaw_error_calc u_err (
        .us_clk        (us_clk),
        .resetn        (resetn),
        .step          (step),
        .sample        (sample_bus.sink),
        .target_angle  (target_angle),
        .yaac_enable_n (yaac_enable_n),
        .error_raw     (error_raw),
        .error_angle   (error_angle)
    );

    assign stick_active = sample_bus.out_of_window;

endmodule

// File: yaw_angle_accumulator_asserts.sv
`timescale 1ns/1ps

module yaw_angle_accumulator_asserts
    import yaw_pkg::*;
(
    input logic   us_clk,
    input logic   resetn,
    input logic   imu_ready,
    input logic   active,
    input logic   complete,
    input angle_t error_angle
);

    int   assert_failures = 0;
    // Sticky once the IMU has reported ready
    logic imu_seen;

    always_ff @(posedge us_clk or negedge resetn) begin
        if (!resetn) begin
            imu_seen <= 1'b0;
        end else if (imu_ready) begin
            imu_seen <= 1'b1;
        end
    end

    // complete is a one-clock pulse
    assert property (@(posedge us_clk) disable iff (!resetn) complete |=> !complete)
        else begin
            $error("complete stayed high for two clocks");
            assert_failures++;
        end

    assert property (@(posedge us_clk) disable iff (!resetn) !(active && complete))
        else begin
            $error("active and complete high together");
            assert_failures++;
        end

    assert property (@(posedge us_clk) disable iff (!resetn)
                     (error_angle >= -ANGLE_90) && (error_angle <= ANGLE_90))
        else begin
            $error("error_angle outside +/-90 degrees");
            assert_failures++;
        end

    // No iteration before the IMU is ready
    assert property (@(posedge us_clk) disable iff (!resetn) !imu_seen |-> (!active && !complete))
        else begin
            $error("iteration ran before imu_ready was seen");
            assert_failures++;
        end

endmodule

bind yaw_angle_accumulator yaw_angle_accumulator_asserts u_asserts (
    .us_clk      (us_clk),
    .resetn      (resetn),
    .imu_ready   (imu_ready),
    .active      (active),
    .complete    (complete),
    .error_angle (error_angle)
);

// File: tb_yaw_angle_accumulator.sv
`timescale 1ns/1ps

module tb_yaw_angle_accumulator
    import yaw_pkg::*;
();

    logic        us_clk;
    logic        resetn;
    stick_t      throttle;
    stick_t      yaw;
    angle_t      imu_angle;
    logic        imu_ready;
    logic        start;
    logic        acro_mode;
    logic        yaac_enable_n;
    angle_t      target_angle;
    angle_t      error_angle;
    logic        active;
    logic        complete;
    logic        stick_active;
    int          errors;
    logic [31:0] seed;
    logic [31:0] rnd;
    // Reference model state and expected outputs
    int          m_neutral;
    int          m_track;
    int          m_track_prev;
    int          m_err_prev;
    int          m_imu;
    int          exp_target;
    int          exp_error;
    int          exp_stick;

    yaw_angle_accumulator i_dut (.*);

    initial begin
        us_clk = 1'b0;
        forever #20 us_clk = ~us_clk;
    end

    function automatic logic [31:0] next_random();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // One iteration of the heading rules, angles in 1/16 degree, track at 4x
    task automatic model_iteration();
        int idle;
        int yaw_raw;
        int norm;
        int sum;
        int tgt;
        int err;
        idle    = (throttle < 8'd10) ? 1 : 0;
        yaw_raw = int'(yaw);
        if (int'(imu_angle) >= 0 && int'(imu_angle) <= 5760) begin
            m_imu = int'(imu_angle);
        end
        if (idle != 0) begin
            m_neutral = yaw_raw;
        end
        norm = acro_mode ? (yaw_raw - m_neutral) * 2 : (yaw_raw - m_neutral) >>> 1;
        exp_stick = (idle == 0 && (norm >= 4 || norm <= -4)) ? 1 : 0;
        sum = m_track + norm;
        if (idle != 0) begin
            m_track = m_imu * 4;
        end else if (exp_stick != 0) begin
            m_track = (sum > 23040) ? sum - 23040 : ((sum < 0) ? sum + 23040 : sum);
        end
        // Stick dropped when the error already sits at a limit
        if ((m_err_prev >= 1440 && norm > 0) || (m_err_prev <= -1440 && norm < 0)) begin
            m_track = m_track_prev;
        end
        tgt = (idle != 0) ? m_imu : (m_track >>> 2);
        if (idle != 0) begin
            err = 0;
        end else if (tgt > 4320 && m_imu < 1440) begin
            err = -(5760 - tgt + m_imu);
        end else if (m_imu > 4320 && tgt < 1440) begin
            err = 5760 - m_imu + tgt;
        end else begin
            err = tgt - m_imu;
        end
        if (m_err_prev >= 1440 && err <= -1440) begin
            err = 1440;
        end else if (m_err_prev <= -1440 && err >= 1440) begin
            err = -1440;
        end
        m_err_prev   = err;
        m_track_prev = m_track;
        exp_target   = yaac_enable_n ? yaw_raw : tgt;
        exp_error    = yaac_enable_n ? 0 : ((err > 1440) ? 1440 : ((err < -1440) ? -1440 : err));
    endtask

    task automatic check_outputs();
        assert (target_angle == angle_t'(exp_target)) else begin
            errors++;
            $display("CHECK FAILED target_angle got %h expected %h",
                     target_angle, angle_t'(exp_target));
        end
        assert (error_angle == angle_t'(exp_error)) else begin
            errors++;
            $display("CHECK FAILED error_angle got %h expected %h",
                     error_angle, angle_t'(exp_error));
        end
        assert (stick_active == exp_stick[0]) else begin
            errors++;
            $display("CHECK FAILED stick_active got %h expected %h", stick_active, exp_stick[0]);
        end
    endtask

    // Poll at the falling edge for complete, or for active when use_complete is low
    task automatic wait_flag(input bit use_complete, input string what);
        int cycles;
        cycles = 0;
        while (!(use_complete ? complete : active) && cycles < 50) begin
            @(negedge us_clk);
            cycles++;
        end
        if (!(use_complete ? complete : active)) begin
            errors++;
            $display("Timeout while waiting for %s", what);
        end
    endtask

    task automatic run_iteration(input stick_t thr, input stick_t yw, input angle_t imu,
                                 input bit acro, input bit bypass);
        @(negedge us_clk);
        throttle      = thr;
        yaw           = yw;
        imu_angle     = imu;
        acro_mode     = acro;
        yaac_enable_n = bypass;
        start         = 1'b1;
        @(negedge us_clk);
        start = 1'b0;
        wait_flag(1'b1, "complete");
        model_iteration();
        check_outputs();
    endtask

    initial begin
        errors        = 0;
        seed          = 32'hd4a0_ba28;
        resetn        = 1'b0;
        throttle      = 8'd0;
        yaw           = 8'd128;
        imu_angle     = 16'sd0;
        imu_ready     = 1'b0;
        start         = 1'b0;
        acro_mode     = 1'b0;
        yaac_enable_n = 1'b0;
        m_neutral     = 0;
        m_track       = 0;
        m_track_prev  = 0;
        m_err_prev    = 0;
        m_imu         = 0;
        repeat (8) @(negedge us_clk);
        resetn = 1'b1;
        // A start before the IMU is ready must not run an iteration
        start = 1'b1;
        repeat (4) @(negedge us_clk);
        start     = 1'b0;
        imu_ready = 1'b1;

        // Idle throttle follows random IMU headings
        repeat (8) begin
            rnd = next_random();
            run_iteration(8'd0, rnd[15:8], angle_t'(rnd[31:16] % 5761), rnd[0], 1'b0);
        end
        // Out-of-range IMU samples are rejected
        run_iteration(8'd0, 8'd128, 16'sd3000, 1'b1, 1'b0);
        run_iteration(8'd0, 8'd128, 16'sd6000, 1'b1, 1'b0);
        run_iteration(8'd0, 8'd128, -16'sd100, 1'b1, 1'b0);
        // Neutral at 128, then small deflections stay in the deadband
        run_iteration(8'd0, 8'd128, 16'sd1000, 1'b1, 1'b0);
        run_iteration(8'd100, 8'd129, 16'sd1000, 1'b1, 1'b0);
        run_iteration(8'd100, 8'd127, 16'sd1000, 1'b1, 1'b0);
        run_iteration(8'd100, 8'd134, 16'sd1000, 1'b0, 1'b0);
        run_iteration(8'd100, 8'd123, 16'sd1000, 1'b0, 1'b0);

        // Random accumulation in acro and easy mode with a steady IMU
        run_iteration(8'd0, 8'd128, 16'sd2000, 1'b1, 1'b0);
        repeat (16) begin
            rnd = next_random();
            run_iteration(8'd60 + rnd[15:12], 8'd98 + stick_t'(rnd[7:0] % 61), 16'sd2000,
                          rnd[8], 1'b0);
        end
        // Wrap upward and downward across 360 degrees
        run_iteration(8'd0, 8'd128, 16'sd5700, 1'b1, 1'b0);
        repeat (3) run_iteration(8'd100, 8'd255, 16'sd5700, 1'b1, 1'b0);
        run_iteration(8'd0, 8'd128, 16'sd20, 1'b1, 1'b0);
        repeat (3) run_iteration(8'd100, 8'd0, 16'sd20, 1'b1, 1'b0);

        // Short path across the seam, then drive into the +90 degree limit and hold it
        run_iteration(8'd0, 8'd128, 16'sd5600, 1'b1, 1'b0);
        run_iteration(8'd100, 8'd128, 16'sd80, 1'b1, 1'b0);
        run_iteration(8'd0, 8'd128, 16'sd2000, 1'b1, 1'b0);
        repeat (30) run_iteration(8'd100, 8'd255, 16'sd2000, 1'b1, 1'b0);
        repeat (3) run_iteration(8'd100, 8'd255, 16'sd5000, 1'b1, 1'b0);
        // Same in the other direction, into the -90 degree limit and hold it
        run_iteration(8'd0, 8'd128, 16'sd2000, 1'b1, 1'b0);
        repeat (30) run_iteration(8'd100, 8'd0, 16'sd2000, 1'b1, 1'b0);
        repeat (3) run_iteration(8'd100, 8'd0, 16'sd4500, 1'b1, 1'b0);

        // Bypass passes the raw stick through
        repeat (4) begin
            rnd = next_random();
            run_iteration(8'd120, rnd[7:0], 16'sd2000, rnd[8], 1'b1);
        end
        // Start held across an iteration gives a second one
        @(negedge us_clk);
        throttle      = 8'd0;
        yaw           = 8'd128;
        imu_angle     = 16'sd900;
        yaac_enable_n = 1'b0;
        start         = 1'b1;
        wait_flag(1'b1, "first complete");
        model_iteration();
        check_outputs();
        wait_flag(1'b0, "second iteration");
        start = 1'b0;
        wait_flag(1'b1, "second complete");
        model_iteration();
        check_outputs();

        $display("Value check errors: %0d, assertion failures: %0d",
                 errors, i_dut.u_asserts.assert_failures);
        if (errors == 0 && i_dut.u_asserts.assert_failures == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: vlog.f
yaw_pkg.sv
yaw_sample_if.sv
yaw_step_sequencer.sv
yaw_stick_conditioner.sv
yaw_target_tracker.sv
yaw_error_calc.sv
yaw_angle_accumulator.sv
yaw_angle_accumulator_asserts.sv
tb_yaw_angle_accumulator.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the yaw angle accumulator testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_yaw_angle_accumulator -f vlog.f -o sim_tb

# Keep running past assertion errors so the testbench prints its result
./obj_dir/sim_tb +verilator+error+limit+100 2>&1 | tee sim.log

if grep -q '\*\* FAIL \*\*' sim.log; then
    echo "Simulation reported failure"
    exit 1
fi
if ! grep -q '\*\* PASS \*\*' sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
echo "Simulation passed"
